/* Makefile */
TOP := decode_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o V$(TOP)

run: compile
	out=$$(./obj_dir/V$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir

/* bench/decode_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_asserts (
  input logic                             CLK,
  input logic                             nRST,
  input logic                             halt,
  input decode_pipe_pkg::hazard_ctrl_t    hazard,
  input decode_pipe_pkg::decode_execute_t decode_execute
);

  logic bubble_due;
  int   fail_count = 0;

  assign bubble_due = ((hazard.id_ex_flush || hazard.stall) && hazard.pc_en) || halt;

  // a bubble must not write the register file
  bubble_clears_wen: assert property (
    @(posedge CLK) disable iff (!nRST) bubble_due |=> !decode_execute.wen
  ) else begin
    $error("wen still high after a bubble");
    fail_count++;
  end

  // frozen register
  hold_keeps_contents: assert property (
    @(posedge CLK) disable iff (!nRST) (!hazard.pc_en && !halt) |=> $stable(decode_execute)
  ) else begin
    $error("id/ex contents changed while pc_en was low");
    fail_count++;
  end

  load_store_exclusive: assert property (
    @(posedge CLK) disable iff (!nRST) !(decode_execute.dwen && decode_execute.dren)
  ) else begin
    $error("dwen and dren both high");
    fail_count++;
  end

endmodule

`default_nettype wire

/* bench/decode_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rv32i_consts.svh"

module decode_tb;

  localparam int N_ALU       = 30;
  localparam int N_OTHER     = 10;
  localparam int N_DIRECTED  = 20;
  localparam int PLANNED     = 2 * N_ALU + 7 * N_OTHER + N_DIRECTED;
  localparam int CYCLE_LIMIT = 4 * PLANNED + 100;

  localparam logic [2:0] LOAD_F3 [5]   = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
  localparam logic [2:0] BRANCH_F3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

  logic                             CLK;
  logic                             nRST;
  logic                             halt;
  decode_pipe_pkg::fetch_decode_t   fetch_decode;
  decode_pipe_pkg::hazard_ctrl_t    hazard;
  rv32i_isa_pkg::word_t             rs1_data;
  rv32i_isa_pkg::word_t             rs2_data;
  rv32i_isa_pkg::reg_addr_t         reg_rs1;
  rv32i_isa_pkg::reg_addr_t         reg_rs2;
  decode_pipe_pkg::decode_execute_t decode_execute;

  rv32i_isa_pkg::word_t             regs [32];
  decode_pipe_pkg::decode_execute_t exp_q [$];
  decode_pipe_pkg::decode_execute_t expected_now = '0;
  integer                           seed = 32'hfb2eb62c;
  int                               value_errors = 0;
  int                               cycles = 0;

  // register file model answers in the same cycle
  assign rs1_data = regs[reg_rs1];
  assign rs2_data = regs[reg_rs2];

  tb_clock_gen u_clock_gen (
    .CLK  (CLK),
    .nRST (nRST)
  );

  decode_stage u_dut (
    .CLK            (CLK),
    .nRST           (nRST),
    .halt           (halt),
    .fetch_decode   (fetch_decode),
    .hazard         (hazard),
    .rs1_data       (rs1_data),
    .rs2_data       (rs2_data),
    .reg_rs1        (reg_rs1),
    .reg_rs2        (reg_rs2),
    .decode_execute (decode_execute)
  );

  bind id_ex_register decode_asserts u_asserts (
    .CLK            (CLK),
    .nRST           (nRST),
    .halt           (halt),
    .hazard         (hazard),
    .decode_execute (decode_execute)
  );

  function automatic logic is_bubble(input decode_pipe_pkg::hazard_ctrl_t hz, input logic hlt);
    return ((hz.id_ex_flush || hz.stall) && hz.pc_en) || hlt;
  endfunction

  function automatic logic is_advance(input decode_pipe_pkg::hazard_ctrl_t hz);
    return hz.pc_en && !hz.stall;
  endfunction

  // alu operation from funct3 and bit 30
  function automatic rv32i_isa_pkg::aluop_t isa_alu_op(input logic [2:0] f3, input logic sub,
                                                      input logic arith);
    case (f3)
      3'b000:  return sub ? rv32i_isa_pkg::ALU_SUB : rv32i_isa_pkg::ALU_ADD;
      3'b001:  return rv32i_isa_pkg::ALU_SLL;
      3'b010:  return rv32i_isa_pkg::ALU_SLT;
      3'b011:  return rv32i_isa_pkg::ALU_SLTU;
      3'b100:  return rv32i_isa_pkg::ALU_XOR;
      3'b101:  return arith ? rv32i_isa_pkg::ALU_SRA : rv32i_isa_pkg::ALU_SRL;
      3'b110:  return rv32i_isa_pkg::ALU_OR;
      default: return rv32i_isa_pkg::ALU_AND;
    endcase
  endfunction

  function automatic decode_pipe_pkg::decode_execute_t ref_decode(
    input rv32i_isa_pkg::word_t instr,
    input rv32i_isa_pkg::word_t pc,
    input rv32i_isa_pkg::word_t rs1v,
    input rv32i_isa_pkg::word_t rs2v
  );
    decode_pipe_pkg::decode_execute_t de;
    logic [2:0]                       f3;
    rv32i_isa_pkg::word_t             imm_i;
    rv32i_isa_pkg::word_t             imm_s;
    rv32i_isa_pkg::word_t             imm_b;
    rv32i_isa_pkg::word_t             imm_u;
    de     = '0;
    f3     = instr[14:12];
    imm_i  = {{20{instr[31]}}, instr[31:20]};
    imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    imm_b  = imm_i;
    imm_u  = {instr[31:12], 12'h000};

    // fields that follow the instruction whatever the opcode
    de.rs1_data  = rs1v;
    de.rs2_data  = rs2v;
    de.reg_rs1   = instr[19:15];
    de.reg_rs2   = instr[24:20];
    de.reg_rd    = instr[11:7];
    de.br_imm_sb = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    de.pc        = pc;
    de.pc4       = pc + 32'd4;
    de.j_base    = rs1v;
    de.j_offset  = imm_i;

    case (instr[6:0])
      `OPC_REGREG: begin
        de.opcode    = rv32i_isa_pkg::REGREG;
        de.alu_op    = isa_alu_op(f3, instr[30], instr[30]);
        de.alu_b_sel = decode_pipe_pkg::B_RS2;
        de.wen       = 1'b1;
      end
      `OPC_IMMED: begin
        de.opcode    = rv32i_isa_pkg::IMMED;
        de.alu_op    = isa_alu_op(f3, 1'b0, instr[30]);
        de.alu_b_sel = decode_pipe_pkg::B_IMM;
        de.wen       = 1'b1;
        if (f3 == 3'b001 || f3 == 3'b101) begin
          imm_b = {27'b0, instr[24:20]};
        end
      end
      `OPC_LOAD: begin
        de.opcode    = rv32i_isa_pkg::LOAD;
        de.alu_b_sel = decode_pipe_pkg::B_IMM;
        de.dren      = 1'b1;
        de.wen       = 1'b1;
        de.load_type = rv32i_isa_pkg::load_t'(f3);
      end
      `OPC_STORE: begin
        de.opcode    = rv32i_isa_pkg::STORE;
        de.alu_a_sel = decode_pipe_pkg::A_IMM_S;
        de.alu_b_sel = decode_pipe_pkg::B_RS1;
        de.dwen      = 1'b1;
      end
      `OPC_LUI: begin
        de.opcode    = rv32i_isa_pkg::LUI;
        de.alu_a_sel = decode_pipe_pkg::A_ZERO;
        de.alu_b_sel = decode_pipe_pkg::B_IMM_U;
        de.w_sel     = decode_pipe_pkg::W_IMM_U;
        de.wen       = 1'b1;
      end
      `OPC_AUIPC: begin
        de.opcode    = rv32i_isa_pkg::AUIPC;
        de.alu_a_sel = decode_pipe_pkg::A_PC;
        de.alu_b_sel = decode_pipe_pkg::B_IMM_U;
        de.wen       = 1'b1;
      end
      `OPC_JAL: begin
        de.opcode   = rv32i_isa_pkg::JAL;
        de.jump     = 1'b1;
        de.j_sel    = 1'b1;
        de.w_sel    = decode_pipe_pkg::W_PC4;
        de.wen      = 1'b1;
        de.j_base   = pc;
        de.j_offset = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      `OPC_JALR: begin
        de.opcode = rv32i_isa_pkg::JALR;
        de.jump   = 1'b1;
        de.w_sel  = decode_pipe_pkg::W_PC4;
        de.wen    = 1'b1;
      end
      `OPC_BRANCH: begin
        de.opcode      = rv32i_isa_pkg::BRANCH;
        de.alu_b_sel   = decode_pipe_pkg::B_RS2;
        de.branch      = 1'b1;
        de.branch_type = rv32i_isa_pkg::branch_t'(f3);
      end
      default: begin
      end
    endcase

    case (de.alu_a_sel)
      decode_pipe_pkg::A_RS1:   de.port_a = rs1v;
      decode_pipe_pkg::A_IMM_S: de.port_a = imm_s;
      decode_pipe_pkg::A_PC:    de.port_a = pc;
      default:                  de.port_a = '0;
    endcase
    case (de.alu_b_sel)
      decode_pipe_pkg::B_RS1: de.port_b = rs1v;
      decode_pipe_pkg::B_RS2: de.port_b = rs2v;
      decode_pipe_pkg::B_IMM: de.port_b = imm_b;
      default:                de.port_b = imm_u;
    endcase
    if (de.w_sel == decode_pipe_pkg::W_PC4) begin
      de.reg_file_wdata = de.pc4;
    end else if (de.w_sel == decode_pipe_pkg::W_IMM_U) begin
      de.reg_file_wdata = imm_u;
    end
    return de;
  endfunction

  task automatic check_value(input string field, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, field, got, exp);
    end
  endtask

  task automatic compare_de(input decode_pipe_pkg::decode_execute_t got,
                            input decode_pipe_pkg::decode_execute_t exp);
    check_value("opcode", 32'(got.opcode), 32'(exp.opcode));
    check_value("alu_op", 32'(got.alu_op), 32'(exp.alu_op));
    check_value("alu_a_sel", 32'(got.alu_a_sel), 32'(exp.alu_a_sel));
    check_value("alu_b_sel", 32'(got.alu_b_sel), 32'(exp.alu_b_sel));
    check_value("port_a", got.port_a, exp.port_a);
    check_value("port_b", got.port_b, exp.port_b);
    check_value("rs1_data", got.rs1_data, exp.rs1_data);
    check_value("rs2_data", got.rs2_data, exp.rs2_data);
    check_value("reg_rs1", 32'(got.reg_rs1), 32'(exp.reg_rs1));
    check_value("reg_rs2", 32'(got.reg_rs2), 32'(exp.reg_rs2));
    check_value("reg_rd", 32'(got.reg_rd), 32'(exp.reg_rd));
    check_value("wen", 32'(got.wen), 32'(exp.wen));
    check_value("dwen", 32'(got.dwen), 32'(exp.dwen));
    check_value("dren", 32'(got.dren), 32'(exp.dren));
    check_value("load_type", 32'(got.load_type), 32'(exp.load_type));
    check_value("w_sel", 32'(got.w_sel), 32'(exp.w_sel));
    check_value("reg_file_wdata", got.reg_file_wdata, exp.reg_file_wdata);
    check_value("jump", 32'(got.jump), 32'(exp.jump));
    check_value("j_sel", 32'(got.j_sel), 32'(exp.j_sel));
    check_value("j_base", got.j_base, exp.j_base);
    check_value("j_offset", got.j_offset, exp.j_offset);
    check_value("branch", 32'(got.branch), 32'(exp.branch));
    check_value("branch_type", 32'(got.branch_type), 32'(exp.branch_type));
    check_value("br_imm_sb", got.br_imm_sb, exp.br_imm_sb);
    check_value("pc", got.pc, exp.pc);
    check_value("pc4", got.pc4, exp.pc4);
  endtask

  function automatic rv32i_isa_pkg::word_t rand_instr(input logic [6:0] opc);
    rv32i_isa_pkg::word_t w;
    w = $random(seed);
    return {w[31:7], opc};
  endfunction

  function automatic rv32i_isa_pkg::word_t aligned_pc();
    rv32i_isa_pkg::word_t w;
    w = $random(seed);
    return {w[31:2], 2'b00};
  endfunction

  // drives one cycle of inputs and queues what the next edge should store
  task automatic issue(input rv32i_isa_pkg::word_t instr, input rv32i_isa_pkg::word_t pc,
                       input logic flush, input logic stall, input logic pc_en,
                       input logic hlt);
    decode_pipe_pkg::hazard_ctrl_t    hz;
    decode_pipe_pkg::decode_execute_t bubble_de;
    hz.id_ex_flush = flush;
    hz.stall       = stall;
    hz.pc_en       = pc_en;
    bubble_de      = '0;
    @(negedge CLK);
    fetch_decode.instr = instr;
    fetch_decode.pc    = pc;
    hazard             = hz;
    halt               = hlt;
    if (is_bubble(hz, hlt)) begin
      exp_q.push_back(bubble_de);
    end else if (is_advance(hz)) begin
      exp_q.push_back(ref_decode(instr, pc, regs[instr[19:15]], regs[instr[24:20]]));
    end
  endtask

  task automatic send(input rv32i_isa_pkg::word_t instr);
    issue(instr, aligned_pc(), 1'b0, 1'b0, 1'b1, 1'b0);
  endtask

  // pop on the rising edge and compare half a cycle later
  always begin : compare_proc
    @(posedge CLK);
    if (nRST) begin
      check_value("reg_rs1 port", 32'(reg_rs1), 32'(fetch_decode.instr[19:15]));
      check_value("reg_rs2 port", 32'(reg_rs2), 32'(fetch_decode.instr[24:20]));
      if (is_bubble(hazard, halt) || is_advance(hazard)) begin
        expected_now = exp_q.pop_front();
      end
    end
    @(negedge CLK);
    compare_de(decode_execute, expected_now);
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    rv32i_isa_pkg::word_t instr;
    int                   i;
    int                   assert_errors;
    halt         = 1'b0;
    hazard       = '0;
    fetch_decode = '0;
    for (i = 0; i < 32; i++) begin
      regs[i] = $random(seed);
    end
    regs[0] = '0;

    @(posedge nRST);
    repeat (2) issue(32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 1'b0);

    // alu instructions with a fixed sub and srai
    send({7'b0100000, 5'd3, 5'd2, 3'b000, 5'd1, `OPC_REGREG});
    send({7'b0100000, 5'd7, 5'd4, 3'b101, 5'd5, `OPC_IMMED});
    for (i = 0; i < N_ALU; i++) begin
      send(rand_instr(`OPC_REGREG));
      send(rand_instr(`OPC_IMMED));
    end

    for (i = 0; i < N_OTHER; i++) begin
      instr        = rand_instr(`OPC_LOAD);
      instr[14:12] = LOAD_F3[i % 5];
      send(instr);
      send(rand_instr(`OPC_STORE));
      send(rand_instr(`OPC_LUI));
      send(rand_instr(`OPC_AUIPC));
    end

    for (i = 0; i < N_OTHER; i++) begin
      send(rand_instr(`OPC_JAL));
      send(rand_instr(`OPC_JALR));
      instr        = rand_instr(`OPC_BRANCH);
      instr[14:12] = BRANCH_F3[i % 6];
      send(instr);
    end

    // holds, bubbles and halt from the hazard levels
    send(rand_instr(`OPC_LUI));
    issue(rand_instr(`OPC_REGREG), aligned_pc(), 1'b0, 1'b0, 1'b0, 1'b0);
    issue(rand_instr(`OPC_IMMED), aligned_pc(), 1'b0, 1'b0, 1'b0, 1'b0);
    issue(rand_instr(`OPC_REGREG), aligned_pc(), 1'b1, 1'b0, 1'b1, 1'b0);
    send(rand_instr(`OPC_LOAD));
    issue(rand_instr(`OPC_STORE), aligned_pc(), 1'b0, 1'b1, 1'b1, 1'b0);
    send(rand_instr(`OPC_JAL));
    issue(rand_instr(`OPC_AUIPC), aligned_pc(), 1'b1, 1'b0, 1'b0, 1'b0);
    issue(rand_instr(`OPC_BRANCH), aligned_pc(), 1'b0, 1'b1, 1'b0, 1'b0);
    issue(rand_instr(`OPC_JALR), aligned_pc(), 1'b0, 1'b0, 1'b1, 1'b1);
    send(rand_instr(`OPC_IMMED));
    issue(rand_instr(`OPC_LUI), aligned_pc(), 1'b0, 1'b0, 1'b0, 1'b1);
    send(rand_instr(7'b1111111));
    send(rand_instr(`OPC_JAL));

    // freeze the register and let the last results drain
    issue(32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 1'b0);
    while (exp_q.size() != 0) begin
      @(negedge CLK);
    end
    repeat (2) @(negedge CLK);
    #1;

    assert_errors = u_dut.u_id_ex_register.u_asserts.fail_count;
    $display("errors: %0d value mismatches, %0d assertion failures",
             value_errors, assert_errors);
    if (value_errors + assert_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic CLK,
  output logic nRST
);

  // 8 ns period
  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // reset held for 16 cycles, released away from the rising edge
  initial begin
    nRST = 1'b0;
    repeat (16) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+rtl
rtl/rv32i_isa_pkg.sv
rtl/decode_pipe_pkg.sv
rtl/control_unit.sv
rtl/operand_select.sv
rtl/id_ex_register.sv
rtl/decode_stage.sv
bench/tb_clock_gen.sv
bench/decode_asserts.sv
bench/decode_tb.sv

/* rtl/control_unit.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rv32i_consts.svh"

module control_unit (
  input  rv32i_isa_pkg::word_t   instr,
  output decode_pipe_pkg::ctrl_t ctrl
);

  logic [`RV_FUNCT3_W-1:0] funct3;
  logic                    alt;
  rv32i_isa_pkg::opcode_t  opcode_raw;

  assign funct3     = instr[`RV_FUNCT3_LSB +: `RV_FUNCT3_W];
  assign alt        = instr[`RV_ALT_BIT];
  assign opcode_raw = rv32i_isa_pkg::opcode_t'(instr[`RV_OPCODE_W-1:0]);

  // alt bit only turns add into sub for register-register ops
  function automatic rv32i_isa_pkg::aluop_t alu_decode(
    input logic [`RV_FUNCT3_W-1:0] f3,
    input logic                    alt_bit,
    input logic                    reg_reg
  );
    rv32i_isa_pkg::aluop_t op;
    case (f3)
      3'b000:  op = (alt_bit && reg_reg) ? rv32i_isa_pkg::ALU_SUB : rv32i_isa_pkg::ALU_ADD;
      3'b001:  op = rv32i_isa_pkg::ALU_SLL;
      3'b010:  op = rv32i_isa_pkg::ALU_SLT;
      3'b011:  op = rv32i_isa_pkg::ALU_SLTU;
      3'b100:  op = rv32i_isa_pkg::ALU_XOR;
      3'b101:  op = alt_bit ? rv32i_isa_pkg::ALU_SRA : rv32i_isa_pkg::ALU_SRL;
      3'b110:  op = rv32i_isa_pkg::ALU_OR;
      default: op = rv32i_isa_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    ctrl = '0;

    // register fields and raw immediates are always sliced
    ctrl.reg_rs1 = instr[`RV_RS1_LSB +: `RV_REG_ADDR_W];
    ctrl.reg_rs2 = instr[`RV_RS2_LSB +: `RV_REG_ADDR_W];
    ctrl.reg_rd  = instr[`RV_RD_LSB +: `RV_REG_ADDR_W];
    ctrl.imm_I   = instr[31:20];
    ctrl.imm_S   = {instr[31:25], instr[11:7]};
    ctrl.imm_SB  = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    ctrl.imm_UJ  = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    ctrl.shamt   = instr[24:20];
    ctrl.imm_U   = {instr[31:12], 12'b0};

    case (opcode_raw)
      rv32i_isa_pkg::REGREG: begin
        ctrl.opcode    = opcode_raw;
        ctrl.alu_op    = alu_decode(funct3, alt, 1'b1);
        ctrl.alu_a_sel = decode_pipe_pkg::A_RS1;
        ctrl.alu_b_sel = decode_pipe_pkg::B_RS2;
        ctrl.wen       = 1'b1;
      end
      rv32i_isa_pkg::IMMED: begin
        ctrl.opcode        = opcode_raw;
        ctrl.alu_op        = alu_decode(funct3, alt, 1'b0);
        ctrl.alu_a_sel     = decode_pipe_pkg::A_RS1;
        ctrl.alu_b_sel     = decode_pipe_pkg::B_IMM;
        // shifts take shamt instead of the I immediate
        ctrl.imm_shamt_sel = (funct3 == 3'b001) || (funct3 == 3'b101);
        ctrl.wen           = 1'b1;
      end
      rv32i_isa_pkg::LOAD: begin
        ctrl.opcode    = opcode_raw;
        ctrl.alu_a_sel = decode_pipe_pkg::A_RS1;
        ctrl.alu_b_sel = decode_pipe_pkg::B_IMM;
        ctrl.dren      = 1'b1;
        ctrl.wen       = 1'b1;
        ctrl.load_type = rv32i_isa_pkg::load_t'(funct3);
      end
      rv32i_isa_pkg::STORE: begin
        // address is imm_S plus rs1
        ctrl.opcode    = opcode_raw;
        ctrl.alu_a_sel = decode_pipe_pkg::A_IMM_S;
        ctrl.alu_b_sel = decode_pipe_pkg::B_RS1;
        ctrl.dwen      = 1'b1;
      end
      rv32i_isa_pkg::LUI: begin
        ctrl.opcode    = opcode_raw;
        ctrl.alu_a_sel = decode_pipe_pkg::A_ZERO;
        ctrl.alu_b_sel = decode_pipe_pkg::B_IMM_U;
        ctrl.w_sel     = decode_pipe_pkg::W_IMM_U;
        ctrl.wen       = 1'b1;
      end
      rv32i_isa_pkg::AUIPC: begin
        ctrl.opcode    = opcode_raw;
        ctrl.alu_a_sel = decode_pipe_pkg::A_PC;
        ctrl.alu_b_sel = decode_pipe_pkg::B_IMM_U;
        ctrl.wen       = 1'b1;
      end
      rv32i_isa_pkg::JAL: begin
        ctrl.opcode = opcode_raw;
        ctrl.jump   = 1'b1;
        ctrl.j_sel  = 1'b1;
        ctrl.w_sel  = decode_pipe_pkg::W_PC4;
        ctrl.wen    = 1'b1;
      end
      rv32i_isa_pkg::JALR: begin
        ctrl.opcode = opcode_raw;
        ctrl.jump   = 1'b1;
        ctrl.w_sel  = decode_pipe_pkg::W_PC4;
        ctrl.wen    = 1'b1;
      end
      rv32i_isa_pkg::BRANCH: begin
        ctrl.opcode      = opcode_raw;
        ctrl.alu_a_sel   = decode_pipe_pkg::A_RS1;
        ctrl.alu_b_sel   = decode_pipe_pkg::B_RS2;
        ctrl.branch      = 1'b1;
        ctrl.branch_type = rv32i_isa_pkg::branch_t'(funct3);
      end
      default: begin
        // unknown opcode leaves every control at zero
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/decode_pipe_pkg.sv */
`default_nettype none

package decode_pipe_pkg;

  // alu operand muxes
  typedef enum logic [1:0] {
    A_RS1   = 2'd0,
    A_IMM_S = 2'd1,
    A_PC    = 2'd2,
    A_ZERO  = 2'd3
  } alu_a_sel_t;

  typedef enum logic [1:0] {
    B_RS1   = 2'd0,
    B_RS2   = 2'd1,
    B_IMM   = 2'd2,
    B_IMM_U = 2'd3
  } alu_b_sel_t;

  // early write-back source
  typedef enum logic [1:0] {
    W_ALU   = 2'd0,
    W_PC4   = 2'd1,
    W_IMM_U = 2'd2
  } w_sel_t;

  typedef struct packed {
    rv32i_isa_pkg::opcode_t   opcode;
    rv32i_isa_pkg::aluop_t    alu_op;
    alu_a_sel_t               alu_a_sel;
    alu_b_sel_t               alu_b_sel;
    logic                     imm_shamt_sel;
    w_sel_t                   w_sel;
    logic                     wen;
    logic                     dwen;
    logic                     dren;
    rv32i_isa_pkg::load_t     load_type;
    logic                     jump;
    logic                     j_sel;
    logic                     branch;
    rv32i_isa_pkg::branch_t   branch_type;
    rv32i_isa_pkg::reg_addr_t reg_rs1;
    rv32i_isa_pkg::reg_addr_t reg_rs2;
    rv32i_isa_pkg::reg_addr_t reg_rd;
    logic [11:0]              imm_I;
    logic [11:0]              imm_S;
    logic [12:0]              imm_SB;
    logic [20:0]              imm_UJ;
    logic [4:0]               shamt;
    rv32i_isa_pkg::word_t     imm_U;
  } ctrl_t;

  typedef struct packed {
    rv32i_isa_pkg::word_t instr;
    rv32i_isa_pkg::word_t pc;
  } fetch_decode_t;

  typedef struct packed {
    logic id_ex_flush;
    logic stall;
    logic pc_en;
  } hazard_ctrl_t;

  typedef struct packed {
    rv32i_isa_pkg::word_t port_a;
    rv32i_isa_pkg::word_t port_b;
    rv32i_isa_pkg::word_t j_base;
    rv32i_isa_pkg::word_t j_offset;
    rv32i_isa_pkg::word_t reg_file_wdata;
    rv32i_isa_pkg::word_t pc4;
    rv32i_isa_pkg::word_t imm_sb_ext;
  } operands_t;

  // contents of the id/ex register
  typedef struct packed {
    rv32i_isa_pkg::opcode_t   opcode;
    rv32i_isa_pkg::aluop_t    alu_op;
    alu_a_sel_t               alu_a_sel;
    alu_b_sel_t               alu_b_sel;
    rv32i_isa_pkg::word_t     port_a;
    rv32i_isa_pkg::word_t     port_b;
    rv32i_isa_pkg::word_t     rs1_data;
    rv32i_isa_pkg::word_t     rs2_data;
    rv32i_isa_pkg::reg_addr_t reg_rs1;
    rv32i_isa_pkg::reg_addr_t reg_rs2;
    rv32i_isa_pkg::reg_addr_t reg_rd;
    logic                     wen;
    logic                     dwen;
    logic                     dren;
    rv32i_isa_pkg::load_t     load_type;
    w_sel_t                   w_sel;
    rv32i_isa_pkg::word_t     reg_file_wdata;
    logic                     jump;
    logic                     j_sel;
    rv32i_isa_pkg::word_t     j_base;
    rv32i_isa_pkg::word_t     j_offset;
    logic                     branch;
    rv32i_isa_pkg::branch_t   branch_type;
    rv32i_isa_pkg::word_t     br_imm_sb;
    rv32i_isa_pkg::word_t     pc;
    rv32i_isa_pkg::word_t     pc4;
  } decode_execute_t;

endpackage

`default_nettype wire

/* rtl/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
  input  logic                             CLK,
  input  logic                             nRST,
  input  logic                             halt,
  input  decode_pipe_pkg::fetch_decode_t   fetch_decode,
  input  decode_pipe_pkg::hazard_ctrl_t    hazard,
  input  rv32i_isa_pkg::word_t             rs1_data,
  input  rv32i_isa_pkg::word_t             rs2_data,
  output rv32i_isa_pkg::reg_addr_t         reg_rs1,
  output rv32i_isa_pkg::reg_addr_t         reg_rs2,
  output decode_pipe_pkg::decode_execute_t decode_execute
);

  decode_pipe_pkg::ctrl_t     ctrl;
  decode_pipe_pkg::operands_t ops;

  // read addresses go to the register file and the hazard unit
  assign reg_rs1 = ctrl.reg_rs1;
  assign reg_rs2 = ctrl.reg_rs2;

  control_unit u_control_unit (
    .instr (fetch_decode.instr),
    .ctrl  (ctrl)
  );

  operand_select u_operand_select (
    .ctrl     (ctrl),
    .pc       (fetch_decode.pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .ops      (ops)
  );

  id_ex_register u_id_ex_register (
    .CLK            (CLK),
    .nRST           (nRST),
    .halt           (halt),
    .hazard         (hazard),
    .ctrl           (ctrl),
    .ops            (ops),
    .rs1_data       (rs1_data),
    .rs2_data       (rs2_data),
    .pc             (fetch_decode.pc),
    .decode_execute (decode_execute)
  );

endmodule

`default_nettype wire

/* rtl/id_ex_register.sv */
`timescale 1ns/1ns
`default_nettype none

module id_ex_register (
  input  logic                             CLK,
  input  logic                             nRST,
  input  logic                             halt,
  input  decode_pipe_pkg::hazard_ctrl_t    hazard,
  input  decode_pipe_pkg::ctrl_t           ctrl,
  input  decode_pipe_pkg::operands_t       ops,
  input  rv32i_isa_pkg::word_t             rs1_data,
  input  rv32i_isa_pkg::word_t             rs2_data,
  input  rv32i_isa_pkg::word_t             pc,
  output decode_pipe_pkg::decode_execute_t decode_execute
);

  decode_pipe_pkg::decode_execute_t next_de;
  logic                             bubble;
  logic                             advance;

  // bubble wins over advance
  assign bubble  = ((hazard.id_ex_flush | hazard.stall) & hazard.pc_en) | halt;
  assign advance = hazard.pc_en & ~hazard.stall;

  always_comb begin
    next_de.opcode         = ctrl.opcode;
    next_de.alu_op         = ctrl.alu_op;
    next_de.alu_a_sel      = ctrl.alu_a_sel;
    next_de.alu_b_sel      = ctrl.alu_b_sel;
    next_de.port_a         = ops.port_a;
    next_de.port_b         = ops.port_b;
    next_de.rs1_data       = rs1_data;
    next_de.rs2_data       = rs2_data;
    next_de.reg_rs1        = ctrl.reg_rs1;
    next_de.reg_rs2        = ctrl.reg_rs2;
    next_de.reg_rd         = ctrl.reg_rd;
    next_de.wen            = ctrl.wen;
    next_de.dwen           = ctrl.dwen;
    next_de.dren           = ctrl.dren;
    next_de.load_type      = ctrl.load_type;
    next_de.w_sel          = ctrl.w_sel;
    next_de.reg_file_wdata = ops.reg_file_wdata;
    next_de.jump           = ctrl.jump;
    next_de.j_sel          = ctrl.j_sel;
    next_de.j_base         = ops.j_base;
    next_de.j_offset       = ops.j_offset;
    next_de.branch         = ctrl.branch;
    next_de.branch_type    = ctrl.branch_type;
    next_de.br_imm_sb      = ops.imm_sb_ext;
    next_de.pc             = pc;
    next_de.pc4            = ops.pc4;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      decode_execute <= '0;
    end else if (bubble) begin
      decode_execute <= '0;
    end else if (advance) begin
      decode_execute <= next_de;
    end
  end

endmodule

`default_nettype wire

/* rtl/operand_select.sv */
`timescale 1ns/1ns
`default_nettype none

module operand_select (
  input  decode_pipe_pkg::ctrl_t     ctrl,
  input  rv32i_isa_pkg::word_t       pc,
  input  rv32i_isa_pkg::word_t       rs1_data,
  input  rv32i_isa_pkg::word_t       rs2_data,
  output decode_pipe_pkg::operands_t ops
);

  rv32i_isa_pkg::word_t imm_i_ext;
  rv32i_isa_pkg::word_t imm_s_ext;
  rv32i_isa_pkg::word_t imm_sb_ext;
  rv32i_isa_pkg::word_t imm_uj_ext;
  rv32i_isa_pkg::word_t imm_b;
  rv32i_isa_pkg::word_t pc4;

  // sign extension of the raw immediates
  assign imm_i_ext  = {{20{ctrl.imm_I[11]}}, ctrl.imm_I};
  assign imm_s_ext  = {{20{ctrl.imm_S[11]}}, ctrl.imm_S};
  assign imm_sb_ext = {{19{ctrl.imm_SB[12]}}, ctrl.imm_SB};
  assign imm_uj_ext = {{11{ctrl.imm_UJ[20]}}, ctrl.imm_UJ};

  // shift amount is zero extended
  assign imm_b = ctrl.imm_shamt_sel ? {27'b0, ctrl.shamt} : imm_i_ext;
  assign pc4   = pc + 32'd4;

  always_comb begin
    case (ctrl.alu_a_sel)
      decode_pipe_pkg::A_RS1:   ops.port_a = rs1_data;
      decode_pipe_pkg::A_IMM_S: ops.port_a = imm_s_ext;
      decode_pipe_pkg::A_PC:    ops.port_a = pc;
      default:                  ops.port_a = '0;
    endcase

    case (ctrl.alu_b_sel)
      decode_pipe_pkg::B_RS1: ops.port_b = rs1_data;
      decode_pipe_pkg::B_RS2: ops.port_b = rs2_data;
      decode_pipe_pkg::B_IMM: ops.port_b = imm_b;
      default:                ops.port_b = ctrl.imm_U;
    endcase

    // jal uses pc relative, jalr uses rs1 relative
    if (ctrl.j_sel) begin
      ops.j_base   = pc;
      ops.j_offset = imm_uj_ext;
    end else begin
      ops.j_base   = rs1_data;
      ops.j_offset = imm_i_ext;
    end

    case (ctrl.w_sel)
      decode_pipe_pkg::W_PC4:   ops.reg_file_wdata = pc4;
      decode_pipe_pkg::W_IMM_U: ops.reg_file_wdata = ctrl.imm_U;
      default:                  ops.reg_file_wdata = '0;
    endcase

    ops.pc4        = pc4;
    ops.imm_sb_ext = imm_sb_ext;
  end

endmodule

`default_nettype wire

/* rtl/rv32i_consts.svh */
`ifndef RV32I_CONSTS_SVH
`define RV32I_CONSTS_SVH

// datapath widths
`define RV_WORD_W       32
`define RV_REG_ADDR_W   5
`define RV_OPCODE_W     7
`define RV_FUNCT3_W     3
`define RV_ALUOP_W      4

// base opcode encodings
`define OPC_LUI         7'b0110111
`define OPC_AUIPC       7'b0010111
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_BRANCH      7'b1100011
`define OPC_LOAD        7'b0000011
`define OPC_STORE       7'b0100011
`define OPC_IMMED       7'b0010011
`define OPC_REGREG      7'b0110011

// instruction field positions
`define RV_RD_LSB       7
`define RV_FUNCT3_LSB   12
`define RV_RS1_LSB      15
`define RV_RS2_LSB      20
`define RV_ALT_BIT      30

`endif

/* rtl/rv32i_isa_pkg.sv */
`default_nettype none
`include "rv32i_consts.svh"

package rv32i_isa_pkg;

  typedef logic [`RV_WORD_W-1:0]     word_t;
  typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

  // base opcodes, zero for anything not decoded
  typedef enum logic [`RV_OPCODE_W-1:0] {
    OPC_NONE = '0,
    LUI      = `OPC_LUI,
    AUIPC    = `OPC_AUIPC,
    JAL      = `OPC_JAL,
    JALR     = `OPC_JALR,
    BRANCH   = `OPC_BRANCH,
    LOAD     = `OPC_LOAD,
    STORE    = `OPC_STORE,
    IMMED    = `OPC_IMMED,
    REGREG   = `OPC_REGREG
  } opcode_t;

  typedef enum logic [`RV_ALUOP_W-1:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } aluop_t;

  // load and branch kinds follow funct3 directly
  typedef enum logic [`RV_FUNCT3_W-1:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } load_t;

  typedef enum logic [`RV_FUNCT3_W-1:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

endpackage

`default_nettype wire
